// File: Bender.yml
package:
  name: mmu_regs

export_include_dirs:
  - logic

sources:
  - files:
      - logic/mmu_regs_pkg.sv
      - logic/mmu_csr_port.sv
      - logic/mmu_index_reg.sv
      - logic/mmu_entry_regs.sv
      - logic/mmu_tlb_cmd_reg.sv
      - logic/mmu_regs.sv
  - target: test
    files:
      - test/mmu_regs_tb.sv

// File: logic/mmu_csr_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_regs_defines.svh"

module mmu_csr_port (
  input  wire                              mmu_regs_clk,
  input  wire                              cpurst_b,
  input  wire mmu_regs_pkg::csr_req_t      csr_req,
  input  wire mmu_regs_pkg::mir_t          mir,
  input  wire mmu_regs_pkg::entry_lo_t     entry_lo,
  input  wire mmu_regs_pkg::entry_hi_t     entry_hi,
  input  wire mmu_regs_pkg::tlb_cmd_e      tlb_cmd,
  input  wire [`MMU_ASID_W-1:0]            inv_asid,
  output mmu_regs_pkg::csr_wr_t            csr_wr,
  output mmu_regs_pkg::tlb_cmd_e           wr_cmd,
  output logic                             wr_no_op,
  output logic [`MMU_DATA_W-1:0]           cp0_data
);

  logic [`MMU_DATA_W-1:0] mir_data;
  logic [`MMU_DATA_W-1:0] mel_data;
  logic [`MMU_DATA_W-1:0] meh_data;
  logic [`MMU_DATA_W-1:0] mcir_data;
  mmu_regs_pkg::csr_sel_e rd_sel;

  //==========================================================================
  //  Write decode
  //==========================================================================
  // Full address match so aliases of the low bits never write
  always_comb
  begin
    csr_wr.mir  = csr_req.wr && (csr_req.addr == `MMU_ADDR_MIR);
    csr_wr.mel  = csr_req.wr && (csr_req.addr == `MMU_ADDR_MEL);
    csr_wr.meh  = csr_req.wr && (csr_req.addr == `MMU_ADDR_MEH);
    csr_wr.mcir = csr_req.wr && (csr_req.addr == `MMU_ADDR_MCIR);
  end

  // Command bits by fixed priority with invalidations first
  always_comb
  begin
    if (csr_req.wdata[`MMU_MCIR_INVALL])
      wr_cmd = mmu_regs_pkg::tlb_cmd_invall;
    else if (csr_req.wdata[`MMU_MCIR_INVASID])
      wr_cmd = mmu_regs_pkg::tlb_cmd_invasid;
    else if (csr_req.wdata[`MMU_MCIR_TLBP])
      wr_cmd = mmu_regs_pkg::tlb_cmd_tlbp;
    else if (csr_req.wdata[`MMU_MCIR_TLBWI])
      wr_cmd = mmu_regs_pkg::tlb_cmd_tlbwi;
    else if (csr_req.wdata[`MMU_MCIR_TLBWR])
      wr_cmd = mmu_regs_pkg::tlb_cmd_tlbwr;
    else if (csr_req.wdata[`MMU_MCIR_TLBR])
      wr_cmd = mmu_regs_pkg::tlb_cmd_tlbr;
    else
      wr_cmd = mmu_regs_pkg::tlb_cmd_none;
  end

  // No command bit set
  assign wr_no_op = (csr_req.wdata[`MMU_MCIR_TLBP:`MMU_MCIR_INVALL] == 6'b0);

  //==========================================================================
  //  Read layouts
  //==========================================================================
  // MIR with P at 31, fatal at 30 and the index at the bottom
  assign mir_data = {32'b0, mir.probe_fail, mir.fatal, 21'b0, mir.index};

  // MEL with so c b sh sec and pmp on top, PPN at 37:10 and D A G U X W R V below
  assign mel_data = {entry_lo.flg[11:7], entry_lo.flg[15:12], 17'b0, entry_lo.ppn, 2'b0,
                     entry_lo.flg[6:5], entry_lo.glb, entry_lo.flg[4:0]};

  assign meh_data = {18'b0, entry_hi.vpn, entry_hi.pgs, entry_hi.asid};

  // One-hot view of the pending command in MCIR
  assign mcir_data = {32'b0,
                      tlb_cmd == mmu_regs_pkg::tlb_cmd_tlbp,
                      tlb_cmd == mmu_regs_pkg::tlb_cmd_tlbr,
                      tlb_cmd == mmu_regs_pkg::tlb_cmd_tlbwi,
                      tlb_cmd == mmu_regs_pkg::tlb_cmd_tlbwr,
                      tlb_cmd == mmu_regs_pkg::tlb_cmd_invasid,
                      tlb_cmd == mmu_regs_pkg::tlb_cmd_invall,
                      10'b0, inv_asid};

  assign rd_sel = mmu_regs_pkg::csr_sel_e'(csr_req.addr[1:0]);

  always_comb
  begin
    case (rd_sel)
      mmu_regs_pkg::csr_sel_mir:  cp0_data = mir_data;
      mmu_regs_pkg::csr_sel_mel:  cp0_data = mel_data;
      mmu_regs_pkg::csr_sel_meh:  cp0_data = meh_data;
      mmu_regs_pkg::csr_sel_mcir: cp0_data = mcir_data;
      default:                    cp0_data = '0;
    endcase
  end

  // Register blocks rely on a single write per cycle
  a_csr_wr_onehot : assert property (@(posedge mmu_regs_clk) disable iff (!cpurst_b)
    $onehot0(csr_wr));

endmodule

`default_nettype wire

// File: logic/mmu_entry_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_regs_defines.svh"

module mmu_entry_regs (
  input  wire                               mmu_regs_clk,
  input  wire                               cpurst_b,
  input  wire                               csr_wr_mel,
  input  wire                               csr_wr_meh,
  input  wire [`MMU_DATA_W-1:0]             wdata,
  input  wire                               tlbr_cmplt,
  input  wire mmu_regs_pkg::tlbr_entry_t    tlbr_entry,
  input  wire                               expt_vld,
  input  wire [`MMU_VPN_W-1:0]              bad_vpn,
  output mmu_regs_pkg::entry_lo_t           entry_lo,
  output mmu_regs_pkg::entry_hi_t           entry_hi
);

  logic [`MMU_FLG_W-1:0] wr_flg;

  //==========================================================================
  //  MEL
  //==========================================================================
  // CSR view
  //   63:59  so c b sh sec
  //   58:55  pmp
  //   37:10  PPN
  //    7:0   D A G U X W R V
  // Stored in joint-TLB order so the entry goes out without a shuffle

  // Reorder the write data into the flag word
  assign wr_flg = {wdata[`MMU_MEL_ATTR_LSB+3:`MMU_MEL_ATTR_LSB],
                   wdata[`MMU_MEL_ATTR_MSB:`MMU_MEL_ATTR_LSB+4],
                   wdata[`MMU_MEL_DIRTY],
                   wdata[`MMU_MEL_ACCESS],
                   wdata[`MMU_MEL_USER],
                   wdata[`MMU_MEL_EXE],
                   wdata[`MMU_MEL_WRITE],
                   wdata[`MMU_MEL_READ],
                   wdata[`MMU_MEL_VALID]};

  always_ff @(posedge mmu_regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_lo <= '0;
    end
    else if (csr_wr_mel)
    begin
      entry_lo.ppn <= wdata[`MMU_MEL_PPN_LSB +: `MMU_PPN_W];
      entry_lo.flg <= wr_flg;
      entry_lo.glb <= wdata[`MMU_MEL_GLOBAL];
    end
    else if (tlbr_cmplt)
    begin
      // TLB read returns the entry already in flag-word order
      entry_lo <= tlbr_entry.lo;
    end
  end

  //==========================================================================
  //  MEH
  //==========================================================================
  // CSR view
  //   45:19  VPN
  //   18:16  page size
  //   15:0   ASID

  always_ff @(posedge mmu_regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_hi <= '0;
    end
    else if (csr_wr_meh)
    begin
      entry_hi.vpn  <= wdata[`MMU_MEH_VPN_MSB:`MMU_MEH_VPN_LSB];
      entry_hi.pgs  <= wdata[`MMU_MEH_PGS_MSB:`MMU_MEH_PGS_LSB];
      entry_hi.asid <= wdata[`MMU_ASID_W-1:0];
    end
    else if (expt_vld)
    begin
      // TLB miss, invalid or modify exception, keep size and ASID
      entry_hi.vpn <= bad_vpn;
    end
    else if (tlbr_cmplt)
    begin
      entry_hi <= tlbr_entry.hi;
    end
  end

  // Exception and TLB read come from different units, never the same cycle
  a_no_expt_tlbr : assert property (@(posedge mmu_regs_clk) disable iff (!cpurst_b)
    !(expt_vld && tlbr_cmplt));

endmodule

`default_nettype wire

// File: logic/mmu_index_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_regs_defines.svh"

module mmu_index_reg (
  input  wire                               mmu_regs_clk,
  input  wire                               cpurst_b,
  input  wire                               csr_wr_mir,
  input  wire [`MMU_DATA_W-1:0]             wdata,
  input  wire                               tlbp_cmplt,
  input  wire mmu_regs_pkg::tlbp_result_t   tlbp_result,
  output mmu_regs_pkg::mir_t                mir
);

  //==========================================================================
  //  MIR
  //==========================================================================
  // P      1 when the probe found no match
  // Fatal  1 when the probe matched more than one entry
  // Index  entry used by tlbwi and tlbr, loaded by software or by a probe hit
  // Status bits are read-only from the CSR side

  always_ff @(posedge mmu_regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      mir <= '0;
    end
    else
    begin
      // Probe status on every completion, hit or miss
      if (tlbp_cmplt)
      begin
        mir.probe_fail <= !tlbp_result.hit;
        mir.fatal      <= tlbp_result.hit_mult;
      end

      // Software write wins over the probe
      if (csr_wr_mir)
      begin
        mir.index <= wdata[`MMU_IDX_W-1:0];
      end
      else if (tlbp_cmplt && tlbp_result.hit)
      begin
        // A miss keeps the old index
        mir.index <= tlbp_result.hit_index;
      end
    end
  end

  // Multiple hit is reported only along with a hit
  a_fatal_with_hit : assert property (@(posedge mmu_regs_clk) disable iff (!cpurst_b)
    mir.fatal |-> !mir.probe_fail);

endmodule

`default_nettype wire

// File: logic/mmu_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_regs_defines.svh"

module mmu_regs (
  input  wire mmu_regs_pkg::csr_req_t      csr_req,
  input  wire                              tlbp_cmplt,
  input  wire mmu_regs_pkg::tlbp_result_t  tlbp_result,
  input  wire                              tlbr_cmplt,
  input  wire mmu_regs_pkg::tlbr_entry_t   tlbr_entry,
  input  wire                              expt_vld,
  input  wire [`MMU_VPN_W-1:0]             bad_vpn,
  input  wire                              tlboper_cmplt,
  input  wire                              mmu_regs_clk,
  input  wire                              cpurst_b,
  output logic [`MMU_DATA_W-1:0]           cp0_data,
  output logic                             cp0_cmplt,
  output mmu_regs_pkg::tlboper_req_t       tlboper_req,
  output mmu_regs_pkg::entry_lo_t          jtlb_entry
);

  mmu_regs_pkg::csr_wr_t   csr_wr;
  mmu_regs_pkg::tlb_cmd_e  wr_cmd;
  logic                    wr_no_op;
  mmu_regs_pkg::mir_t      mir;
  mmu_regs_pkg::entry_lo_t entry_lo;
  mmu_regs_pkg::entry_hi_t entry_hi;
  mmu_regs_pkg::tlb_cmd_e  tlb_cmd;
  logic [`MMU_ASID_W-1:0]  inv_asid;

  //==========================================================================
  //  CSR port
  //==========================================================================
  mmu_csr_port i_mmu_csr_port (
    .mmu_regs_clk (mmu_regs_clk),
    .cpurst_b     (cpurst_b),
    .csr_req      (csr_req),
    .mir          (mir),
    .entry_lo     (entry_lo),
    .entry_hi     (entry_hi),
    .tlb_cmd      (tlb_cmd),
    .inv_asid     (inv_asid),
    .csr_wr       (csr_wr),
    .wr_cmd       (wr_cmd),
    .wr_no_op     (wr_no_op),
    .cp0_data     (cp0_data)
  );

  //==========================================================================
  //  Register blocks
  //==========================================================================
  mmu_index_reg i_mmu_index_reg (
    .mmu_regs_clk (mmu_regs_clk),
    .cpurst_b     (cpurst_b),
    .csr_wr_mir   (csr_wr.mir),
    .wdata        (csr_req.wdata),
    .tlbp_cmplt   (tlbp_cmplt),
    .tlbp_result  (tlbp_result),
    .mir          (mir)
  );

  mmu_entry_regs i_mmu_entry_regs (
    .mmu_regs_clk (mmu_regs_clk),
    .cpurst_b     (cpurst_b),
    .csr_wr_mel   (csr_wr.mel),
    .csr_wr_meh   (csr_wr.meh),
    .wdata        (csr_req.wdata),
    .tlbr_cmplt   (tlbr_cmplt),
    .tlbr_entry   (tlbr_entry),
    .expt_vld     (expt_vld),
    .bad_vpn      (bad_vpn),
    .entry_lo     (entry_lo),
    .entry_hi     (entry_hi)
  );

  mmu_tlb_cmd_reg i_mmu_tlb_cmd_reg (
    .mmu_regs_clk  (mmu_regs_clk),
    .cpurst_b      (cpurst_b),
    .csr_wr_mcir   (csr_wr.mcir),
    .wr_cmd        (wr_cmd),
    .wr_no_op      (wr_no_op),
    .wdata         (csr_req.wdata),
    .tlboper_cmplt (tlboper_cmplt),
    .tlb_cmd       (tlb_cmd),
    .inv_asid      (inv_asid),
    .cp0_cmplt     (cp0_cmplt)
  );

  // Request to the TLB operation unit
  assign tlboper_req = '{cmd: tlb_cmd, inv_asid: inv_asid, index: mir.index, hi: entry_hi};

  // Joint-TLB write data
  assign jtlb_entry = entry_lo;

endmodule

`default_nettype wire

// File: logic/mmu_regs_defines.svh
`ifndef MMU_REGS_DEFINES_SVH
`define MMU_REGS_DEFINES_SVH

// Field widths of the TLB entry and the CSR port
`define MMU_VPN_W   27
`define MMU_PPN_W   28
`define MMU_FLG_W   16
`define MMU_PGS_W   3
`define MMU_ASID_W  16
`define MMU_IDX_W   9
`define MMU_DATA_W  64
`define MMU_ADDR_W  12

// CSR addresses, low two bits select the register on reads
`define MMU_ADDR_MIR   12'h9C0
`define MMU_ADDR_MEL   12'h9C1
`define MMU_ADDR_MEH   12'h9C2
`define MMU_ADDR_MCIR  12'h9C3

// MEL layout
`define MMU_MEL_PPN_LSB   10
`define MMU_MEL_ATTR_MSB  63
`define MMU_MEL_ATTR_LSB  55
`define MMU_MEL_DIRTY     7
`define MMU_MEL_ACCESS    6
`define MMU_MEL_GLOBAL    5
`define MMU_MEL_USER      4
`define MMU_MEL_EXE       3
`define MMU_MEL_WRITE     2
`define MMU_MEL_READ      1
`define MMU_MEL_VALID     0

// MEH layout, ASID sits at the bottom
`define MMU_MEH_VPN_MSB   45
`define MMU_MEH_VPN_LSB   19
`define MMU_MEH_PGS_MSB   18
`define MMU_MEH_PGS_LSB   16

// MIR status bits
`define MMU_MIR_PROBE     31
`define MMU_MIR_FATAL     30

// MCIR command bits
`define MMU_MCIR_TLBP     31
`define MMU_MCIR_TLBR     30
`define MMU_MCIR_TLBWI    29
`define MMU_MCIR_TLBWR    28
`define MMU_MCIR_INVASID  27
`define MMU_MCIR_INVALL   26

`endif

// File: logic/mmu_regs_pkg.sv
`default_nettype none
`include "mmu_regs_defines.svh"

package mmu_regs_pkg;

  // Read select, taken from the low CSR address bits
  typedef enum logic [1:0] {
    csr_sel_mir  = 2'd0,
    csr_sel_mel  = 2'd1,
    csr_sel_meh  = 2'd2,
    csr_sel_mcir = 2'd3
  } csr_sel_e;

  // Pending TLB maintenance command
  typedef enum logic [2:0] {
    tlb_cmd_none    = 3'd0,
    tlb_cmd_invall  = 3'd1,
    tlb_cmd_invasid = 3'd2,
    tlb_cmd_tlbp    = 3'd3,
    tlb_cmd_tlbwi   = 3'd4,
    tlb_cmd_tlbwr   = 3'd5,
    tlb_cmd_tlbr    = 3'd6
  } tlb_cmd_e;

  // CSR request from the coprocessor
  typedef struct packed {
    logic                   wr;
    logic [`MMU_ADDR_W-1:0] addr;
    logic [`MMU_DATA_W-1:0] wdata;
  } csr_req_t;

  // One write strobe per register
  typedef struct packed {
    logic mir;
    logic mel;
    logic meh;
    logic mcir;
  } csr_wr_t;

  // Entry low half
  // Flag word: pmp 15:12, so c b sh sec 11:7, dirty access 6:5, u x w r v 4:0
  typedef struct packed {
    logic [`MMU_PPN_W-1:0] ppn;
    logic [`MMU_FLG_W-1:0] flg;
    logic                  glb;
  } entry_lo_t;

  // Entry high half
  typedef struct packed {
    logic [`MMU_VPN_W-1:0]  vpn;
    logic [`MMU_PGS_W-1:0]  pgs;
    logic [`MMU_ASID_W-1:0] asid;
  } entry_hi_t;

  typedef struct packed {
    logic                  hit;
    logic                  hit_mult;
    logic [`MMU_IDX_W-1:0] hit_index;
  } tlbp_result_t;

  typedef struct packed {
    entry_hi_t hi;
    entry_lo_t lo;
  } tlbr_entry_t;

  typedef struct packed {
    logic                  probe_fail;
    logic                  fatal;
    logic [`MMU_IDX_W-1:0] index;
  } mir_t;

  // Request to the TLB operation unit
  typedef struct packed {
    tlb_cmd_e               cmd;
    logic [`MMU_ASID_W-1:0] inv_asid;
    logic [`MMU_IDX_W-1:0]  index;
    entry_hi_t              hi;
  } tlboper_req_t;

endpackage

`default_nettype wire

// File: logic/mmu_tlb_cmd_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_regs_defines.svh"

module mmu_tlb_cmd_reg (
  input  wire                            mmu_regs_clk,
  input  wire                            cpurst_b,
  input  wire                            csr_wr_mcir,
  input  wire mmu_regs_pkg::tlb_cmd_e    wr_cmd,
  input  wire                            wr_no_op,
  input  wire [`MMU_DATA_W-1:0]          wdata,
  input  wire                            tlboper_cmplt,
  output mmu_regs_pkg::tlb_cmd_e         tlb_cmd,
  output logic [`MMU_ASID_W-1:0]         inv_asid,
  output logic                           cp0_cmplt
);

  logic no_op_q;

  //==========================================================================
  //  MCIR command
  //==========================================================================
  // 31 tlbp, 30 tlbr, 29 tlbwi, 28 tlbwr, 27 invasid, 26 invall
  // 15:0 ASID for invalidation
  // Only one command is pending at a time

  always_ff @(posedge mmu_regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      tlb_cmd <= mmu_regs_pkg::tlb_cmd_none;
    end
    else if (csr_wr_mcir && !wr_no_op)
    begin
      // Newer command replaces the pending one
      tlb_cmd <= wr_cmd;
    end
    else if (tlboper_cmplt)
    begin
      tlb_cmd <= mmu_regs_pkg::tlb_cmd_none;
    end
  end

  // ASID taken on every MCIR write, used by invasid
  always_ff @(posedge mmu_regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      inv_asid <= '0;
    end
    else if (csr_wr_mcir)
    begin
      inv_asid <= wdata[`MMU_ASID_W-1:0];
    end
  end

  //==========================================================================
  //  Completion
  //==========================================================================
  // A write with no command bits has nothing to wait for
  // Complete it on the next cycle
  always_ff @(posedge mmu_regs_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      no_op_q <= 1'b0;
    end
    else
    begin
      no_op_q <= csr_wr_mcir && wr_no_op;
    end
  end

  assign cp0_cmplt = tlboper_cmplt || no_op_q;

  // CSR writes are never back to back, so the no-op pulse is one cycle
  a_no_op_pulse : assert property (@(posedge mmu_regs_clk) disable iff (!cpurst_b)
    no_op_q |=> !no_op_q);

endmodule

`default_nettype wire

// File: mmu_regs.f
+incdir+logic
logic/mmu_regs_pkg.sv
logic/mmu_csr_port.sv
logic/mmu_index_reg.sv
logic/mmu_entry_regs.sv
logic/mmu_tlb_cmd_reg.sv
logic/mmu_regs.sv
test/mmu_regs_tb.sv

// File: test/mmu_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_regs_defines.svh"

module mmu_regs_tb;

  localparam int CLK_PERIOD = 100;
  localparam int SEED       = 68789;
  localparam int N_WR       = 30;
  localparam int N_CMD      = 20;
  localparam int N_PRB      = 20;
  localparam int N_RD       = 30;
  // Worst-case cycles per item: write 2, command 8, probe 2, TLB read 3
  localparam int RUN_CYCLES = 3 + 8 + N_WR * 2 + N_CMD * 8 + N_PRB * 2 + N_RD * 3;
  localparam int MARGIN     = 100;
  // Readable bits of MEL and MEH in the CSR view
  localparam logic [63:0] MEL_MASK = 64'hFF80_003F_FFFF_FCFF;
  localparam logic [63:0] MEH_MASK = 64'h0000_3FFF_FFFF_FFFF;

  logic                         mmu_regs_clk;
  logic                         cpurst_b;
  mmu_regs_pkg::csr_req_t       csr_req;
  logic                         tlbp_cmplt;
  mmu_regs_pkg::tlbp_result_t   tlbp_result;
  logic                         tlbr_cmplt;
  mmu_regs_pkg::tlbr_entry_t    tlbr_entry;
  logic                         expt_vld;
  logic [`MMU_VPN_W-1:0]        bad_vpn;
  logic                         tlboper_cmplt;
  logic [`MMU_DATA_W-1:0]       cp0_data;
  logic                         cp0_cmplt;
  mmu_regs_pkg::tlboper_req_t   tlboper_req;
  mmu_regs_pkg::entry_lo_t      jtlb_entry;

  // Reference model, MEL and MEH kept in their CSR view
  logic [63:0]                  m_mel;
  logic [63:0]                  m_meh;
  logic [8:0]                   m_idx;
  logic                         m_probe_fail;
  logic                         m_fatal;
  mmu_regs_pkg::tlb_cmd_e       m_cmd;
  logic [15:0]                  m_asid;

  int                           n_checks;
  int                           n_errors;
  int                           t_checks;
  int                           t_errors;
  int                           i;
  int                           sel;
  int                           kind;
  int                           delay;
  logic [63:0]                  data;
  logic [95:0]                  rnd;
  logic [5:0]                   bits;
  logic                         coin;

  mmu_regs i_mmu_regs (
    .csr_req       (csr_req),
    .tlbp_cmplt    (tlbp_cmplt),
    .tlbp_result   (tlbp_result),
    .tlbr_cmplt    (tlbr_cmplt),
    .tlbr_entry    (tlbr_entry),
    .expt_vld      (expt_vld),
    .bad_vpn       (bad_vpn),
    .tlboper_cmplt (tlboper_cmplt),
    .mmu_regs_clk  (mmu_regs_clk),
    .cpurst_b      (cpurst_b),
    .cp0_data      (cp0_data),
    .cp0_cmplt     (cp0_cmplt),
    .tlboper_req   (tlboper_req),
    .jtlb_entry    (jtlb_entry)
  );

  always #(CLK_PERIOD / 2) mmu_regs_clk = ~mmu_regs_clk;

  //==========================================================================
  //  Reference views
  //==========================================================================
  // CSR view of MEL into the joint-TLB flag word
  function automatic mmu_regs_pkg::entry_lo_t entry_from_mel(input logic [63:0] v);
    mmu_regs_pkg::entry_lo_t lo;
    lo            = '0;
    lo.ppn        = v[`MMU_MEL_PPN_LSB +: `MMU_PPN_W];
    lo.flg[15:12] = v[58:55];
    lo.flg[11:7]  = v[63:59];
    lo.flg[6]     = v[`MMU_MEL_DIRTY];
    lo.flg[5]     = v[`MMU_MEL_ACCESS];
    lo.flg[4:0]   = v[4:0];
    lo.glb        = v[`MMU_MEL_GLOBAL];
    return lo;
  endfunction

  // Flag word back into the CSR view
  function automatic logic [63:0] mel_from_entry(input mmu_regs_pkg::entry_lo_t lo);
    logic [63:0] v;
    v                     = '0;
    v[37:10]              = lo.ppn;
    v[58:55]              = lo.flg[15:12];
    v[63:59]              = lo.flg[11:7];
    v[`MMU_MEL_DIRTY]     = lo.flg[6];
    v[`MMU_MEL_ACCESS]    = lo.flg[5];
    v[`MMU_MEL_GLOBAL]    = lo.glb;
    v[4:0]                = lo.flg[4:0];
    return v;
  endfunction

  function automatic logic [63:0] mir_word();
    logic [63:0] v;
    v                 = '0;
    v[`MMU_MIR_PROBE] = m_probe_fail;
    v[`MMU_MIR_FATAL] = m_fatal;
    v[8:0]            = m_idx;
    return v;
  endfunction

  // One-hot command bit plus the invalidation ASID
  function automatic logic [63:0] mcir_word();
    logic [63:0] v;
    v = '0;
    case (m_cmd)
      mmu_regs_pkg::tlb_cmd_tlbp:    v[`MMU_MCIR_TLBP]    = 1'b1;
      mmu_regs_pkg::tlb_cmd_tlbr:    v[`MMU_MCIR_TLBR]    = 1'b1;
      mmu_regs_pkg::tlb_cmd_tlbwi:   v[`MMU_MCIR_TLBWI]   = 1'b1;
      mmu_regs_pkg::tlb_cmd_tlbwr:   v[`MMU_MCIR_TLBWR]   = 1'b1;
      mmu_regs_pkg::tlb_cmd_invasid: v[`MMU_MCIR_INVASID] = 1'b1;
      mmu_regs_pkg::tlb_cmd_invall:  v[`MMU_MCIR_INVALL]  = 1'b1;
      default:                       v = '0;
    endcase
    v[15:0] = m_asid;
    return v;
  endfunction

  function automatic logic [63:0] expected_read(input logic [1:0] a);
    case (a)
      2'd0:    return mir_word();
      2'd1:    return m_mel;
      2'd2:    return m_meh;
      default: return mcir_word();
    endcase
  endfunction

  // Bits 31:26 in order tlbp tlbr tlbwi tlbwr invasid invall
  function automatic mmu_regs_pkg::tlb_cmd_e decode_command(input logic [5:0] b);
    if (b[0])      return mmu_regs_pkg::tlb_cmd_invall;
    else if (b[1]) return mmu_regs_pkg::tlb_cmd_invasid;
    else if (b[5]) return mmu_regs_pkg::tlb_cmd_tlbp;
    else if (b[3]) return mmu_regs_pkg::tlb_cmd_tlbwi;
    else if (b[2]) return mmu_regs_pkg::tlb_cmd_tlbwr;
    else if (b[4]) return mmu_regs_pkg::tlb_cmd_tlbr;
    else           return mmu_regs_pkg::tlb_cmd_none;
  endfunction

  //==========================================================================
  //  Drive and compare
  //==========================================================================
  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("ERR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Next falling edge with every strobe low
  task automatic drive_idle();
    @(negedge mmu_regs_clk);
    csr_req.wr    = 1'b0;
    tlbp_cmplt    = 1'b0;
    tlbr_cmplt    = 1'b0;
    expt_vld      = 1'b0;
    tlboper_cmplt = 1'b0;
  endtask

  task automatic drive_write(input logic [1:0] a, input logic [63:0] d);
    csr_req.wr    = 1'b1;
    csr_req.addr  = `MMU_ADDR_MIR + a;
    csr_req.wdata = d;
  endtask

  // Read is combinational, sampled well inside the low phase
  task automatic read_and_compare(input logic [1:0] a, input string name);
    drive_idle();
    csr_req.addr = `MMU_ADDR_MIR + a;
    #20;
    compare_value(name, cp0_data, expected_read(a));
  endtask

  task automatic start_test();
    t_checks = n_checks;
    t_errors = n_errors;
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d errors", name, n_checks - t_checks, n_errors - t_errors);
  endtask

  //==========================================================================
  //  Watchdog
  //==========================================================================
  initial
  begin
    #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES + MARGIN);
    $display("Test FAILED");
    $finish;
  end

  //==========================================================================
  //  Stimulus
  //==========================================================================
  initial
  begin
    mmu_regs_clk  = 1'b0;
    cpurst_b      = 1'b0;
    csr_req       = '0;
    tlbp_cmplt    = 1'b0;
    tlbp_result   = '0;
    tlbr_cmplt    = 1'b0;
    tlbr_entry    = '0;
    expt_vld      = 1'b0;
    bad_vpn       = '0;
    tlboper_cmplt = 1'b0;
    m_mel         = '0;
    m_meh         = '0;
    m_idx         = '0;
    m_probe_fail  = 1'b0;
    m_fatal       = 1'b0;
    m_cmd         = mmu_regs_pkg::tlb_cmd_none;
    m_asid        = '0;
    n_checks      = 0;
    n_errors      = 0;
    data          = $urandom(SEED);

    repeat (3) @(negedge mmu_regs_clk);
    cpurst_b = 1'b1;

    // Reset values
    start_test();
    for (i = 0; i < 4; i++)
      read_and_compare(i[1:0], "cp0_data");
    compare_value("tlboper_req.cmd", tlboper_req.cmd, mmu_regs_pkg::tlb_cmd_none);
    compare_value("cp0_cmplt", cp0_cmplt, 1'b0);
    compare_value("jtlb_entry", jtlb_entry, '0);
    finish_test("reset");

    // CSR writes to MIR, MEL and MEH, each read back
    start_test();
    for (i = 0; i < N_WR; i++)
    begin
      sel  = $urandom % 3;
      data = {$urandom, $urandom};
      drive_idle();
      drive_write(sel[1:0], data);
      case (sel)
        0:       m_idx = data[8:0];
        1:       m_mel = data & MEL_MASK;
        default: m_meh = data & MEH_MASK;
      endcase
      read_and_compare(sel[1:0], "cp0_data");
      compare_value("jtlb_entry", jtlb_entry, entry_from_mel(m_mel));
      compare_value("tlboper_req.index", tlboper_req.index, m_idx);
      compare_value("tlboper_req.hi", tlboper_req.hi, m_meh[45:0]);
    end
    finish_test("register writes");

    // MCIR commands, held until the operation unit completes
    start_test();
    for (i = 0; i < N_CMD; i++)
    begin
      kind = $urandom % 4;
      if (kind == 0)
        bits = 6'b0;
      else if (kind == 1)
        bits = 6'b1 << ($urandom % 6);
      else
        bits = $urandom;
      data        = {$urandom, $urandom};
      data[31:26] = bits;
      drive_idle();
      drive_write(2'd3, data);
      m_asid = data[15:0];
      if (bits == 6'b0)
      begin
        // No-op completes on the following cycle only
        drive_idle();
        #20;
        compare_value("cp0_cmplt", cp0_cmplt, 1'b1);
        compare_value("tlboper_req.cmd", tlboper_req.cmd, m_cmd);
        drive_idle();
        #20;
        compare_value("cp0_cmplt", cp0_cmplt, 1'b0);
        read_and_compare(2'd3, "cp0_data");
      end
      else
      begin
        m_cmd = decode_command(bits);
        delay = 1 + $urandom % 4;
        repeat (delay)
        begin
          read_and_compare(2'd3, "cp0_data");
          compare_value("tlboper_req.cmd", tlboper_req.cmd, m_cmd);
          compare_value("tlboper_req.inv_asid", tlboper_req.inv_asid, m_asid);
          compare_value("cp0_cmplt", cp0_cmplt, 1'b0);
        end
        drive_idle();
        tlboper_cmplt = 1'b1;
        #20;
        compare_value("cp0_cmplt", cp0_cmplt, 1'b1);
        compare_value("tlboper_req.cmd", tlboper_req.cmd, m_cmd);
        m_cmd = mmu_regs_pkg::tlb_cmd_none;
        drive_idle();
        #20;
        compare_value("tlboper_req.cmd", tlboper_req.cmd, m_cmd);
        compare_value("cp0_cmplt", cp0_cmplt, 1'b0);
      end
    end
    finish_test("commands");

    // Probe results, some along with a MIR write
    start_test();
    for (i = 0; i < N_PRB; i++)
    begin
      drive_idle();
      tlbp_result.hit       = $urandom % 2;
      tlbp_result.hit_mult  = tlbp_result.hit && ($urandom % 4 == 0);
      tlbp_result.hit_index = $urandom;
      tlbp_cmplt            = 1'b1;
      coin                  = ($urandom % 4 == 0);
      data                  = {$urandom, $urandom};
      if (coin)
        drive_write(2'd0, data);
      m_probe_fail = !tlbp_result.hit;
      m_fatal      = tlbp_result.hit_mult;
      if (coin)
        m_idx = data[8:0];
      else if (tlbp_result.hit)
        m_idx = tlbp_result.hit_index;
      read_and_compare(2'd0, "cp0_data");
      compare_value("tlboper_req.index", tlboper_req.index, m_idx);
    end
    finish_test("probe");

    // TLB reads and exceptions, some along with an MEL or MEH write
    start_test();
    for (i = 0; i < N_RD; i++)
    begin
      kind = $urandom % 4;
      sel  = 1 + $urandom % 2;
      rnd  = {$urandom, $urandom, $urandom};
      data = {$urandom, $urandom};
      drive_idle();
      tlbr_entry = rnd[90:0];
      bad_vpn    = $urandom;
      tlbr_cmplt = (kind == 0) || (kind == 2);
      expt_vld   = (kind == 1) || (kind == 3);
      if (kind >= 2)
        drive_write(sel[1:0], data);
      // CSR write first, then exception, then TLB read
      if (kind >= 2 && sel == 1)
        m_mel = data & MEL_MASK;
      else if (tlbr_cmplt)
        m_mel = mel_from_entry(tlbr_entry.lo);
      if (kind >= 2 && sel == 2)
        m_meh = data & MEH_MASK;
      else if (expt_vld)
        m_meh[45:19] = bad_vpn;
      else if (tlbr_cmplt)
        m_meh = {18'b0, tlbr_entry.hi};
      read_and_compare(2'd1, "cp0_data");
      read_and_compare(2'd2, "cp0_data");
      compare_value("jtlb_entry", jtlb_entry, entry_from_mel(m_mel));
    end
    finish_test("tlb read and exception");

    $display("Total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
